// ==== sim.f ====
hw/matmul_geom_pkg.sv
hw/matmul_sched_pkg.sv
hw/matmul_sequencer.sv
hw/operand_feeder.sv
hw/mac_pe.sv
hw/pe_array.sv
hw/result_drain.sv
hw/matmul_top.sv
verif/matmul_assertions.sv
verif/tb_matmul.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_matmul
FILELIST  := sim.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== verif/tb_matmul.sv ====
`timescale 1ns/1ns

module tb_matmul;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 5;
  localparam int DRIVE_DELAY = 1;
  localparam logic [31:0] SEED = 32'h69b2;
  localparam int FULL_MASK_RUNS = 20;
  localparam int MASKED_RUNS = 8;
  localparam int BIG_OPERAND_RUNS = 4;
  localparam int RUN_TIMEOUT = 64;
  localparam int QUIET_CYCLES = 30;

  logic                                clk;
  logic                                reset;
  logic                                i_start;
  logic [matmul_geom_pkg::ADDR_W-1:0]   i_a_base;
  logic [matmul_geom_pkg::ADDR_W-1:0]   i_b_base;
  logic [matmul_geom_pkg::ADDR_W-1:0]   i_c_base;
  logic [matmul_geom_pkg::STRIDE_W-1:0] i_a_stride;
  logic [matmul_geom_pkg::STRIDE_W-1:0] i_b_stride;
  logic [matmul_geom_pkg::STRIDE_W-1:0] i_c_stride;
  logic [matmul_geom_pkg::ROW_W-1:0]    i_a_data;
  logic [matmul_geom_pkg::ROW_W-1:0]    i_b_data;
  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_a_row_mask;
  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_k_mask;
  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_b_col_mask;
  logic [matmul_geom_pkg::ADDR_W-1:0]   o_a_addr;
  logic [matmul_geom_pkg::ADDR_W-1:0]   o_b_addr;
  logic [matmul_geom_pkg::ADDR_W-1:0]   o_c_addr;
  logic [matmul_geom_pkg::ROW_W-1:0]    o_c_data;
  logic                                o_c_valid;
  logic                                o_done;

  // Memory contents, the LCG state and the model's result matrix
  logic [matmul_geom_pkg::ROW_W-1:0]  mem_a [matmul_geom_pkg::MEM_DEPTH];
  logic [matmul_geom_pkg::ROW_W-1:0]  mem_b [matmul_geom_pkg::MEM_DEPTH];
  logic [matmul_geom_pkg::ADDR_W-1:0] a_addr_seen;
  logic [matmul_geom_pkg::ADDR_W-1:0] b_addr_seen;
  logic [31:0]                        lcg_state;
  logic [matmul_geom_pkg::DATA_W-1:0] exp_c [matmul_geom_pkg::MAT_SIZE][matmul_geom_pkg::MAT_SIZE];

  matmul_top u_dut (.*);

  bind matmul_top matmul_assertions u_assertions (
    .clk       (clk),
    .reset     (reset),
    .i_start   (i_start),
    .i_c_valid (o_c_valid),
    .i_done    (o_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Read ports answer one cycle after the address, the data changing just after the edge
  initial begin
    i_a_data = '0;
    i_b_data = '0;
    a_addr_seen = '0;
    b_addr_seen = '0;
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      i_a_data = mem_a[a_addr_seen];
      i_b_data = mem_b[b_addr_seen];
      a_addr_seen = o_a_addr;
      b_addr_seen = o_b_addr;
    end
  end

  ////////////////////////////////
  // Helpers
  ////////////////////////////////

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // The high bits of the LCG are the well mixed ones
  function automatic int rand_below(input int n);
    logic [31:0] v;
    v = next_rand();
    return int'(v[30:8]) % n;
  endfunction

  function automatic logic [31:0] rand_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = next_rand();
    lo = next_rand();
    return {hi[31:16], lo[31:16]};
  endfunction

  // Signed product clipped to the 8-bit range
  function automatic logic [7:0] sat_product(input logic signed [7:0] a,
                                             input logic signed [7:0] b);
    int p;
    p = int'(a) * int'(b);
    if (p > 127) begin
      return 8'h7f;
    end else if (p < -128) begin
      return 8'h80;
    end
    return p[7:0];
  endfunction

  task automatic next_drive_slot();
    @(posedge clk);
    #DRIVE_DELAY;
  endtask

  task automatic fail_now(input string what);
    $display("%s at %0t ns", what, $time);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("mismatch at %0t ns: %s expected %h got %h", $time, sig, exp, got);
    $display("Result: FAILED");
    $fatal(1);
  endtask

  // Base and stride are drawn so that four beats never run past the top of memory
  task automatic pick_range(output logic [matmul_geom_pkg::ADDR_W-1:0] base,
                            output logic [matmul_geom_pkg::STRIDE_W-1:0] stride);
    int s;
    int b;
    s = rand_below(256);
    b = rand_below(matmul_geom_pkg::MEM_DEPTH - (matmul_geom_pkg::MAT_SIZE - 1) * s);
    stride = s[matmul_geom_pkg::STRIDE_W-1:0];
    base = b[matmul_geom_pkg::ADDR_W-1:0];
  endtask

  // Bytes near the ends of the signed range, so nearly every product saturates
  function automatic logic [31:0] big_word();
    logic [31:0] w;
    for (int n = 0; n < 4; n++) begin
      case (rand_below(3))
        0:       w[n*8 +: 8] = 8'h7f;
        1:       w[n*8 +: 8] = 8'h80;
        default: w[n*8 +: 8] = 8'h81;
      endcase
    end
    return w;
  endfunction

  // C[r][j] is the wrapped sum over k of the clipped products of the kept elements
  task automatic compute_expected();
    int a_addr;
    int b_addr;
    logic [7:0] a_el;
    logic [7:0] b_el;
    logic [7:0] acc;
    for (int r = 0; r < matmul_geom_pkg::MAT_SIZE; r++) begin
      for (int j = 0; j < matmul_geom_pkg::MAT_SIZE; j++) begin
        acc = '0;
        for (int k = 0; k < matmul_geom_pkg::MAT_SIZE; k++) begin
          a_addr = int'(i_a_base) + k * int'(i_a_stride);
          b_addr = int'(i_b_base) + k * int'(i_b_stride);
          a_el = (i_a_row_mask[r] && i_k_mask[k]) ? mem_a[a_addr][r*8 +: 8] : 8'h00;
          b_el = (i_b_col_mask[j] && i_k_mask[k]) ? mem_b[b_addr][j*8 +: 8] : 8'h00;
          acc = acc + sat_product(a_el, b_el);
        end
        exp_c[r][j] = acc;
      end
    end
  endtask

  ////////////////////////////////
  // Run setup and checking
  ////////////////////////////////

  // Mode 0 keeps every element, mode 1 draws masks, mode 2 loads extreme operands
  task automatic setup_run(input int mode);
    int v;
    pick_range(i_a_base, i_a_stride);
    pick_range(i_b_base, i_b_stride);
    pick_range(i_c_base, i_c_stride);
    i_a_row_mask = '1;
    i_b_col_mask = '1;
    i_k_mask = '1;
    if (mode == 1) begin
      v = rand_below(16);
      i_a_row_mask = v[3:0];
      v = rand_below(16);
      i_b_col_mask = v[3:0];
      v = rand_below(16);
      i_k_mask = v[3:0];
    end else if (mode == 2) begin
      for (int k = 0; k < matmul_geom_pkg::MAT_SIZE; k++) begin
        mem_a[int'(i_a_base) + k * int'(i_a_stride)] = big_word();
        mem_b[int'(i_b_base) + k * int'(i_b_stride)] = big_word();
      end
    end
    compute_expected();
  endtask

  task automatic check_quiet(input int cycles);
    for (int n = 0; n < cycles; n++) begin
      @(negedge clk);
      assert (!o_c_valid) else fail_now("o_c_valid high while the design should be idle");
      assert (!o_done) else fail_now("o_done high while the design should be idle");
    end
  endtask

  // Raises start, follows the run to done and checks addresses and columns on the way
  task automatic run_and_check();
    int cyc;
    int beats;
    bit finished;
    logic [matmul_geom_pkg::ADDR_W-1:0] exp_a;
    logic [matmul_geom_pkg::ADDR_W-1:0] exp_b;
    logic [matmul_geom_pkg::ADDR_W-1:0] exp_addr;
    logic [matmul_geom_pkg::ROW_W-1:0]  exp_word;
    i_start = 1'b1;
    cyc = 0;
    beats = 0;
    finished = 1'b0;
    while (!finished) begin
      @(negedge clk);
      // Beat k has its read address out in cycle k+1
      if (cyc >= 1 && cyc <= matmul_geom_pkg::MAT_SIZE) begin
        exp_a = i_a_base + (cyc - 1) * i_a_stride;
        exp_b = i_b_base + (cyc - 1) * i_b_stride;
        assert (o_a_addr == exp_a) else report_mismatch("o_a_addr", 32'(exp_a), 32'(o_a_addr));
        assert (o_b_addr == exp_b) else report_mismatch("o_b_addr", 32'(exp_b), 32'(o_b_addr));
      end
      if (o_c_valid) begin
        assert (beats < matmul_geom_pkg::MAT_SIZE)
          else fail_now("o_c_valid carried more than four columns");
        for (int r = 0; r < matmul_geom_pkg::MAT_SIZE; r++) begin
          exp_word[r*8 +: 8] = exp_c[r][beats];
        end
        exp_addr = i_c_base + beats * i_c_stride;
        assert (o_c_data == exp_word) else report_mismatch("o_c_data", exp_word, o_c_data);
        assert (o_c_addr == exp_addr)
          else report_mismatch("o_c_addr", 32'(exp_addr), 32'(o_c_addr));
        beats++;
      end
      if (o_done) begin
        assert (beats == matmul_geom_pkg::MAT_SIZE)
          else fail_now("o_done arrived before all four columns were written");
        finished = 1'b1;
      end
      cyc++;
      assert (finished || cyc < RUN_TIMEOUT) else fail_now("timeout waiting for o_done");
    end
    // No second pulse while start stays high, nothing once it falls
    check_quiet(4);
    next_drive_slot();
    i_start = 1'b0;
    check_quiet(3);
  endtask

  ////////////////////////////////
  // Main sequence
  ////////////////////////////////

  initial begin
    int abort_cycle;
    lcg_state = SEED;
    reset = 1'b1;
    i_start = 1'b0;
    i_a_base = '0;
    i_b_base = '0;
    i_c_base = '0;
    i_a_stride = '0;
    i_b_stride = '0;
    i_c_stride = '0;
    i_a_row_mask = '1;
    i_k_mask = '1;
    i_b_col_mask = '1;
    for (int n = 0; n < matmul_geom_pkg::MEM_DEPTH; n++) begin
      mem_a[n] = rand_word();
      mem_b[n] = rand_word();
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;
    check_quiet(3);

    for (int n = 0; n < FULL_MASK_RUNS + MASKED_RUNS + BIG_OPERAND_RUNS; n++) begin
      next_drive_slot();
      setup_run((n < FULL_MASK_RUNS) ? 0 : (n < FULL_MASK_RUNS + MASKED_RUNS) ? 1 : 2);
      next_drive_slot();
      run_and_check();
    end

    // Abort somewhere between the fetch and the middle of the drain
    next_drive_slot();
    setup_run(1);
    next_drive_slot();
    i_start = 1'b1;
    abort_cycle = 3 + rand_below(15);
    repeat (abort_cycle) next_drive_slot();
    i_start = 1'b0;
    check_quiet(QUIET_CYCLES);

    // The run after an abort starts from a clean array
    next_drive_slot();
    setup_run(1);
    next_drive_slot();
    run_and_check();

    $display("Result: PASSED");
    $finish;
  end

endmodule

// ==== verif/matmul_assertions.sv ====
`timescale 1ns/1ns

module matmul_assertions (
  input logic clk,
  input logic reset,
  input logic i_start,
  input logic i_c_valid,
  input logic i_done
);

  // Length of the current burst of valid cycles, held once it reaches five
  logic [2:0] valid_run_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_run_q <= '0;
    end else if (!i_c_valid) begin
      valid_run_q <= '0;
    end else if (valid_run_q != 3'd5) begin
      valid_run_q <= valid_run_q + 1'b1;
    end
  end

  ////////////////////////////////
  // Output protocol
  ////////////////////////////////

  // Done is a single-cycle pulse
  done_single_cycle: assert property (@(posedge clk) disable iff (reset) i_done |=> !i_done)
    else $error("o_done stayed high for more than one cycle");

  // One column per valid cycle, so a burst holds at most four beats
  valid_burst_limit: assert property (@(posedge clk) disable iff (reset)
    i_c_valid |-> (valid_run_q < 3'd4))
    else $error("o_c_valid stayed high for more than four cycles in a row");

  // With start low the design sits idle
  idle_outputs_low: assert property (@(posedge clk) disable iff (reset)
    !i_start |-> (!i_c_valid && !i_done))
    else $error("o_c_valid or o_done high while i_start is low");

endmodule

// ==== hw/matmul_top.sv ====
`timescale 1ns/1ns

module matmul_top (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_start,
  input  logic [matmul_geom_pkg::ADDR_W-1:0]   i_a_base,
  input  logic [matmul_geom_pkg::ADDR_W-1:0]   i_b_base,
  input  logic [matmul_geom_pkg::ADDR_W-1:0]   i_c_base,
  input  logic [matmul_geom_pkg::STRIDE_W-1:0] i_a_stride,
  input  logic [matmul_geom_pkg::STRIDE_W-1:0] i_b_stride,
  input  logic [matmul_geom_pkg::STRIDE_W-1:0] i_c_stride,
  input  logic [matmul_geom_pkg::ROW_W-1:0]    i_a_data,
  input  logic [matmul_geom_pkg::ROW_W-1:0]    i_b_data,
  input  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_a_row_mask,
  input  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_k_mask,
  input  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_b_col_mask,
  output logic [matmul_geom_pkg::ADDR_W-1:0]   o_a_addr,
  output logic [matmul_geom_pkg::ADDR_W-1:0]   o_b_addr,
  output logic [matmul_geom_pkg::ADDR_W-1:0]   o_c_addr,
  output logic [matmul_geom_pkg::ROW_W-1:0]    o_c_data,
  output logic                                o_c_valid,
  output logic                                o_done
);

  logic                                clear;
  logic                                fetch_en;
  logic                                capture;
  logic [matmul_geom_pkg::ROW_W-1:0]   a_lanes;
  logic [matmul_geom_pkg::ROW_W-1:0]   b_lanes;
  logic [matmul_geom_pkg::SUMS_W-1:0]  sums;

  ////////////////////////////////
  // Control
  ////////////////////////////////

  matmul_sequencer u_sequencer (
    .clk        (clk),
    .reset      (reset),
    .i_start    (i_start),
    .o_clear    (clear),
    .o_fetch_en (fetch_en),
    .o_capture  (capture),
    .o_done     (o_done)
  );

  ////////////////////////////////
  // Operand feeders
  ////////////////////////////////

  // A lanes are rows of A, so the row mask qualifies them
  operand_feeder u_a_feeder (
    .clk         (clk),
    .reset       (reset),
    .i_clear     (clear),
    .i_fetch_en  (fetch_en),
    .i_base      (i_a_base),
    .i_stride    (i_a_stride),
    .i_mem_data  (i_a_data),
    .i_lane_mask (i_a_row_mask),
    .i_k_mask    (i_k_mask),
    .o_addr      (o_a_addr),
    .o_lanes     (a_lanes)
  );

  // B lanes are columns of B
  operand_feeder u_b_feeder (
    .clk         (clk),
    .reset       (reset),
    .i_clear     (clear),
    .i_fetch_en  (fetch_en),
    .i_base      (i_b_base),
    .i_stride    (i_b_stride),
    .i_mem_data  (i_b_data),
    .i_lane_mask (i_b_col_mask),
    .i_k_mask    (i_k_mask),
    .o_addr      (o_b_addr),
    .o_lanes     (b_lanes)
  );

  ////////////////////////////////
  // Datapath and output
  ////////////////////////////////

  pe_array u_array (
    .clk       (clk),
    .i_clear   (clear),
    .i_a_lanes (a_lanes),
    .i_b_lanes (b_lanes),
    .o_sums    (sums)
  );

  result_drain u_drain (
    .clk        (clk),
    .reset      (reset),
    .i_clear    (clear),
    .i_capture  (capture),
    .i_sums     (sums),
    .i_c_base   (i_c_base),
    .i_c_stride (i_c_stride),
    .o_c_addr   (o_c_addr),
    .o_c_data   (o_c_data),
    .o_c_valid  (o_c_valid)
  );

endmodule

// ==== hw/result_drain.sv ====
`timescale 1ns/1ns

module result_drain (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  logic                                i_capture,
  input  logic [matmul_geom_pkg::SUMS_W-1:0]   i_sums,
  input  logic [matmul_geom_pkg::ADDR_W-1:0]   i_c_base,
  input  logic [matmul_geom_pkg::STRIDE_W-1:0] i_c_stride,
  output logic [matmul_geom_pkg::ADDR_W-1:0]   o_c_addr,
  output logic [matmul_geom_pkg::ROW_W-1:0]    o_c_data,
  output logic                                o_c_valid
);

  logic                                          active_q;
  logic [$clog2(matmul_geom_pkg::MAT_SIZE)-1:0]  col_q;
  logic [$clog2(matmul_geom_pkg::MAT_SIZE)-1:0]  col_nxt;
  logic [matmul_geom_pkg::ADDR_W-1:0]            addr_q;
  logic [matmul_geom_pkg::ROW_W-1:0]             data_q;
  logic [matmul_geom_pkg::ROW_W-1:0]             col_word;
  logic [matmul_geom_pkg::ADDR_W-1:0]            stride_ext;

  assign stride_ext = {{(matmul_geom_pkg::ADDR_W - matmul_geom_pkg::STRIDE_W){1'b0}}, i_c_stride};

  ////////////////////////////////
  // Column sequencing
  ////////////////////////////////

  // Column 0 goes out the cycle after capture, the rest follow back to back
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      active_q <= 1'b0;
      col_q    <= '0;
      addr_q   <= '0;
    end else if (i_capture) begin
      active_q <= 1'b1;
      col_q    <= '0;
      addr_q   <= i_c_base;
    end else if (active_q) begin
      // The last column ends the burst, the counter wraps back to zero
      if (col_q == ($clog2(matmul_geom_pkg::MAT_SIZE))'(matmul_geom_pkg::MAT_SIZE - 1)) begin
        active_q <= 1'b0;
      end
      col_q  <= col_q + 1'b1;
      addr_q <= addr_q + stride_ext;
    end
  end

  ////////////////////////////////
  // Column select
  ////////////////////////////////

  // Index of the column that goes out in the next cycle
  assign col_nxt = i_capture ? '0 : col_q + 1'b1;

  // Lane r of the output word is C[r][j], taken from the row-major sum bus
  always_comb begin
    for (int r = 0; r < matmul_geom_pkg::MAT_SIZE; r++) begin
      col_word[r*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W] =
        i_sums[(r*matmul_geom_pkg::MAT_SIZE + int'(col_nxt))*matmul_geom_pkg::DATA_W +:
               matmul_geom_pkg::DATA_W];
    end
  end

  // The data word is registered alongside the address
  always_ff @(posedge clk) begin
    if (i_capture || active_q) begin
      data_q <= col_word;
    end
  end

  assign o_c_addr = addr_q;
  assign o_c_data = data_q;

  // An abort drops valid in the same cycle
  assign o_c_valid = active_q & ~i_clear;

endmodule

// ==== hw/pe_array.sv ====
`timescale 1ns/1ns

module pe_array (
  input  logic                              clk,
  input  logic                              i_clear,
  input  logic [matmul_geom_pkg::ROW_W-1:0]  i_a_lanes,
  input  logic [matmul_geom_pkg::ROW_W-1:0]  i_b_lanes,
  output logic [matmul_geom_pkg::SUMS_W-1:0] o_sums
);

  // Horizontal links carry A rightward, one extra column for the right edge
  logic [matmul_geom_pkg::DATA_W-1:0] a_link [matmul_geom_pkg::MAT_SIZE][matmul_geom_pkg::MAT_SIZE+1];

  // Vertical links carry B downward, one extra row for the bottom edge
  logic [matmul_geom_pkg::DATA_W-1:0] b_link [matmul_geom_pkg::MAT_SIZE+1][matmul_geom_pkg::MAT_SIZE];

  ////////////////////////////////
  // Edge inputs
  ////////////////////////////////

  // Row r is fed by A lane r and column j by B lane j
  for (genvar n = 0; n < matmul_geom_pkg::MAT_SIZE; n++) begin : g_edge
    assign a_link[n][0] = i_a_lanes[n*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W];
    assign b_link[0][n] = i_b_lanes[n*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W];
  end

  ////////////////////////////////
  // Element grid
  ////////////////////////////////

  // The right and bottom edge links end here unread
  for (genvar r = 0; r < matmul_geom_pkg::MAT_SIZE; r++) begin : g_row
    for (genvar j = 0; j < matmul_geom_pkg::MAT_SIZE; j++) begin : g_col
      mac_pe u_pe (
        .clk     (clk),
        .i_clear (i_clear),
        .i_a     (a_link[r][j]),
        .i_b     (b_link[r][j]),
        .o_a     (a_link[r][j+1]),
        .o_b     (b_link[r+1][j]),
        .o_sum   (o_sums[(r*matmul_geom_pkg::MAT_SIZE+j)*matmul_geom_pkg::DATA_W +:
                         matmul_geom_pkg::DATA_W])
      );
    end
  end

endmodule

// ==== hw/mac_pe.sv ====
`timescale 1ns/1ns

module mac_pe (
  input  logic                              clk,
  input  logic                              i_clear,
  input  logic [matmul_geom_pkg::DATA_W-1:0] i_a,
  input  logic [matmul_geom_pkg::DATA_W-1:0] i_b,
  output logic [matmul_geom_pkg::DATA_W-1:0] o_a,
  output logic [matmul_geom_pkg::DATA_W-1:0] o_b,
  output logic [matmul_geom_pkg::DATA_W-1:0] o_sum
);

  logic signed [matmul_geom_pkg::DATA_W-1:0] a_q;
  logic signed [matmul_geom_pkg::DATA_W-1:0] b_q;
  logic signed [matmul_geom_pkg::PROD_W-1:0] prod_q;
  logic signed [matmul_geom_pkg::DATA_W-1:0] prod_sat;
  logic        [matmul_geom_pkg::DATA_W-1:0] acc_q;

  // High bits above the 8-bit result, sign bit included
  logic [matmul_geom_pkg::PROD_W-matmul_geom_pkg::DATA_W:0] prod_top;

  // Stage 1 registers the operands.
  // The same registers feed the right and lower neighbours
  always_ff @(posedge clk) begin
    if (i_clear) begin
      a_q <= '0;
      b_q <= '0;
    end else begin
      a_q <= i_a;
      b_q <= i_b;
    end
  end

  assign o_a = a_q;
  assign o_b = b_q;

  // Stage 2 holds the full signed product
  always_ff @(posedge clk) begin
    if (i_clear) begin
      prod_q <= '0;
    end else begin
      prod_q <= a_q * b_q;
    end
  end

  // The product fits in 8 bits only when its top bits are a pure sign extension
  assign prod_top = prod_q[matmul_geom_pkg::PROD_W-1:matmul_geom_pkg::DATA_W-1];

  always_comb begin
    if ((&prod_top) || !(|prod_top)) begin
      prod_sat = prod_q[matmul_geom_pkg::DATA_W-1:0];
    end else if (prod_q[matmul_geom_pkg::PROD_W-1]) begin
      // Clip to -128
      prod_sat = {1'b1, {(matmul_geom_pkg::DATA_W-1){1'b0}}};
    end else begin
      // Clip to +127
      prod_sat = {1'b0, {(matmul_geom_pkg::DATA_W-1){1'b1}}};
    end
  end

  // Stage 3 accumulates, the sum wraps modulo 256 by design
  always_ff @(posedge clk) begin
    if (i_clear) begin
      acc_q <= '0;
    end else begin
      acc_q <= acc_q + prod_sat;
    end
  end

  assign o_sum = acc_q;

endmodule

// ==== hw/operand_feeder.sv ====
`timescale 1ns/1ns

module operand_feeder (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                i_clear,
  input  logic                                i_fetch_en,
  input  logic [matmul_geom_pkg::ADDR_W-1:0]   i_base,
  input  logic [matmul_geom_pkg::STRIDE_W-1:0] i_stride,
  input  logic [matmul_geom_pkg::ROW_W-1:0]    i_mem_data,
  input  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_lane_mask,
  input  logic [matmul_geom_pkg::MAT_SIZE-1:0] i_k_mask,
  output logic [matmul_geom_pkg::ADDR_W-1:0]   o_addr,
  output logic [matmul_geom_pkg::ROW_W-1:0]    o_lanes
);

  // Number of beats issued so far in this run
  logic [$clog2(matmul_sched_pkg::FETCH_BEATS):0] beat_q;
  logic [matmul_geom_pkg::ADDR_W-1:0]             addr_q;

  // Beat valid and beat index, first through the address phase
  // and then through the read latency
  logic [matmul_sched_pkg::MEM_LATENCY:0]           vld_pipe_q;
  logic [$clog2(matmul_geom_pkg::MAT_SIZE)-1:0]      kidx_pipe_q [matmul_sched_pkg::MEM_LATENCY+1];

  logic [matmul_geom_pkg::ROW_W-1:0]   masked;
  logic [matmul_geom_pkg::ADDR_W-1:0]  stride_ext;
  logic                                beat_ok;

  assign stride_ext = {{(matmul_geom_pkg::ADDR_W - matmul_geom_pkg::STRIDE_W){1'b0}}, i_stride};

  ////////////////////////////////
  // Strided address walk
  ////////////////////////////////

  // The first beat loads the base directly, so a base driven in the
  // same cycle as start is still picked up
  always_ff @(posedge clk) begin
    if (reset || i_clear) begin
      beat_q <= '0;
      addr_q <= i_base;
    end else if (i_fetch_en) begin
      beat_q <= beat_q + 1'b1;
      addr_q <= (beat_q == '0) ? i_base : addr_q + stride_ext;
    end
  end

  assign o_addr = addr_q;

  // Stage 0 covers the cycle with the address out, the last stage
  // lines up with the word on the read port
  always_ff @(posedge clk) begin
    if (i_clear) begin
      vld_pipe_q <= '0;
      for (int i = 0; i <= matmul_sched_pkg::MEM_LATENCY; i++) begin
        kidx_pipe_q[i] <= '0;
      end
    end else begin
      vld_pipe_q     <= {vld_pipe_q[matmul_sched_pkg::MEM_LATENCY-1:0], i_fetch_en};
      kidx_pipe_q[0] <= beat_q[$clog2(matmul_geom_pkg::MAT_SIZE)-1:0];
      for (int i = 1; i <= matmul_sched_pkg::MEM_LATENCY; i++) begin
        kidx_pipe_q[i] <= kidx_pipe_q[i-1];
      end
    end
  end

  ////////////////////////////////
  // Validity masking
  ////////////////////////////////

  // A beat counts only while its data is on the port and its k bit is set
  assign beat_ok = vld_pipe_q[matmul_sched_pkg::MEM_LATENCY]
                 & i_k_mask[kidx_pipe_q[matmul_sched_pkg::MEM_LATENCY]];

  always_comb begin
    for (int r = 0; r < matmul_geom_pkg::MAT_SIZE; r++) begin
      masked[r*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W] =
        (beat_ok && i_lane_mask[r]) ?
        i_mem_data[r*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W] : '0;
    end
  end

  ////////////////////////////////
  // Skew registers
  ////////////////////////////////

  // Lane r is held back r cycles so the wavefront enters the grid diagonally
  for (genvar r = 0; r < matmul_geom_pkg::MAT_SIZE; r++) begin : g_skew
    if (r == 0) begin : g_direct
      assign o_lanes[0 +: matmul_geom_pkg::DATA_W] = masked[0 +: matmul_geom_pkg::DATA_W];
    end else begin : g_delay
      logic [matmul_geom_pkg::DATA_W-1:0] dly_q [r];

      always_ff @(posedge clk) begin
        if (i_clear) begin
          for (int i = 0; i < r; i++) begin
            dly_q[i] <= '0;
          end
        end else begin
          dly_q[0] <= masked[r*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W];
          for (int i = 1; i < r; i++) begin
            dly_q[i] <= dly_q[i-1];
          end
        end
      end

      assign o_lanes[r*matmul_geom_pkg::DATA_W +: matmul_geom_pkg::DATA_W] = dly_q[r-1];
    end
  end

endmodule

// ==== hw/matmul_sequencer.sv ====
`timescale 1ns/1ns

module matmul_sequencer (
  input  logic clk,
  input  logic reset,
  input  logic i_start,
  output logic o_clear,
  output logic o_fetch_en,
  output logic o_capture,
  output logic o_done
);

  // Run cycle counter, zero while idle and in cycle 0 of a run
  logic [matmul_sched_pkg::CNT_W-1:0] cnt_q;

  // The only place where start and reset meet.
  // Every datapath block treats clear as its reset and abort
  assign o_clear = reset | ~i_start;

  ////////////////////////////////
  // Cycle counter
  ////////////////////////////////

  // Counting stops one past the done count, so done fires exactly once
  // and the design then idles until start falls
  always_ff @(posedge clk) begin
    if (o_clear) begin
      cnt_q <= '0;
    end else if (cnt_q <= matmul_sched_pkg::DONE_CNT) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  ////////////////////////////////
  // Schedule decode
  ////////////////////////////////

  // Beat k is issued in cycle k, its address goes out in cycle k+1
  assign o_fetch_en = i_start & (cnt_q < matmul_sched_pkg::FETCH_BEATS);

  // Single-cycle strobe telling the drain that the sums are final
  assign o_capture = i_start & (cnt_q == matmul_sched_pkg::CAPTURE_CNT);

  // Follows the last drained column.
  // Gated by start so that an abort drops it in the same cycle
  assign o_done = i_start & (cnt_q == matmul_sched_pkg::DONE_CNT);

endmodule

// ==== hw/matmul_sched_pkg.sv ====
package matmul_sched_pkg;

  ////////////////////////////////
  // Run schedule for a 4x4 pass
  ////////////////////////////////

  // Wide enough for the whole run plus the idle hold after done
  localparam int CNT_W = 8;

  // One fetch beat per column of A and row of B
  localparam int FETCH_BEATS = 4;

  // Cycles from an address on the bus to its data on the read port
  localparam int MEM_LATENCY = 1;

  // Beat 3 reaches the corner element last.
  // Its data returns in cycle 5, is skewed by 3, walks 3 more elements
  // and then takes 3 pipeline stages, so cycle 14 is the first cycle
  // in which every accumulator is final. Capture is decoded one cycle later
  localparam int CAPTURE_CNT = 15;

  // Four columns drain after capture, then done follows the last one
  localparam int DONE_CNT = CAPTURE_CNT + matmul_geom_pkg::MAT_SIZE + 1;

endpackage

// ==== hw/matmul_geom_pkg.sv ====
package matmul_geom_pkg;

  ////////////////////////////////
  // Array and data geometry
  ////////////////////////////////

  // The grid is square, so one dimension covers rows, columns and beats
  localparam int MAT_SIZE = 4;

  // Signed element width of A, B and C
  localparam int DATA_W = 8;

  // A memory word carries one full column of A or one full row of B
  localparam int ROW_W = MAT_SIZE * DATA_W;

  ////////////////////////////////
  // Memory addressing
  ////////////////////////////////

  localparam int ADDR_W = 11;
  localparam int STRIDE_W = 8;
  localparam int MEM_DEPTH = 2048;

  // Full signed product before it is clipped back to DATA_W
  localparam int PROD_W = 2 * DATA_W;

  // All sixteen sums side by side, row-major
  localparam int SUMS_W = MAT_SIZE * MAT_SIZE * DATA_W;

endpackage
